// File: design/bank_decode.sv
`timescale 1ns/1ns

module bank_decode (
  input  logic                           we,
  input  ram_pkg::addr_t                 waddr,
  input  logic                           re,
  input  ram_pkg::addr_t                 raddr,
  output logic [ram_pkg::num_banks-1:0]  bank_we,
  output logic [ram_pkg::num_banks-1:0]  bank_re,
  output ram_pkg::bank_addr_t            bank_waddr,
  output ram_pkg::bank_addr_t            bank_raddr,
  output ram_pkg::bank_sel_t             rd_bank
);

  import ram_pkg::*;

  bank_sel_t wr_idx;       // bank picked by the write address.
  bank_sel_t rd_idx;       // bank picked by the read address.
  logic      wr_in_range;
  logic      rd_in_range;

  // top bits choose the bank, the rest go to every bank unchanged.
  assign wr_idx     = waddr[$bits(addr_t)-1 -: $bits(bank_sel_t)];
  assign rd_idx     = raddr[$bits(addr_t)-1 -: $bits(bank_sel_t)];
  assign bank_waddr = waddr[$bits(bank_addr_t)-1:0];
  assign bank_raddr = raddr[$bits(bank_addr_t)-1:0];

  // addresses 1536 and up have no bank.
  assign wr_in_range = (waddr < mem_depth);
  assign rd_in_range = (raddr < mem_depth);

  // one-hot write enable, only while we is high.
  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      bank_we[b] = we && wr_in_range && (wr_idx == bank_sel_t'(b));
    end
  end

  // one-hot read enable, so only the addressed bank toggles its output.
  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      bank_re[b] = re && rd_in_range && (rd_idx == bank_sel_t'(b));
    end
  end

  // index handed to the read selector, all ones when nothing is addressed.
  always_comb begin
    if (rd_in_range) begin
      rd_bank = rd_idx;
    end else begin
      rd_bank = '1;          // out of range, selector returns zero.
    end
  end

endmodule

// File: design/ram_1536x8.sv
`timescale 1ns/1ns

module ram_1536x8 (
  input  logic            wclk,
  input  logic            rclk,
  input  logic            rst_n,
  input  logic            we,
  input  logic            re,
  input  ram_pkg::addr_t  waddr,
  input  ram_pkg::addr_t  raddr,
  input  ram_pkg::data_t  wdata,
  output ram_pkg::data_t  rdata,
  output logic            rvalid
);

  import ram_pkg::*;

  logic [num_banks-1:0]  bank_we;      // one-hot write enables.
  logic [num_banks-1:0]  bank_re;      // one-hot read enables.
  bank_addr_t            bank_waddr;
  bank_addr_t            bank_raddr;
  bank_sel_t             rd_bank;
  data_t [num_banks-1:0] bank_rdata;   // registered outputs of all banks.

  // address split and enable decode.
  bank_decode u_decode (
    .we         (we),
    .waddr      (waddr),
    .re         (re),
    .raddr      (raddr),
    .bank_we    (bank_we),
    .bank_re    (bank_re),
    .bank_waddr (bank_waddr),
    .bank_raddr (bank_raddr),
    .rd_bank    (rd_bank)
  );

  // three identical banks share the write data and both local addresses.
  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    ram_bank_512x8 u_bank (
      .wclk  (wclk),
      .we    (bank_we[b]),
      .waddr (bank_waddr),
      .wdata (wdata),
      .rclk  (rclk),
      .re    (bank_re[b]),
      .raddr (bank_raddr),
      .rdata (bank_rdata[b])
    );
  end

  // output mux driven by the registered bank index.
  read_select u_select (
    .rclk       (rclk),
    .rst_n      (rst_n),
    .re         (re),
    .rd_bank    (rd_bank),
    .bank_rdata (bank_rdata),
    .rdata      (rdata),
    .rvalid     (rvalid)
  );

endmodule

// File: design/ram_bank_512x8.sv
`timescale 1ns/1ns

module ram_bank_512x8 (
  input  logic                 wclk,
  input  logic                 we,
  input  ram_pkg::bank_addr_t  waddr,
  input  ram_pkg::data_t       wdata,
  input  logic                 rclk,
  input  logic                 re,
  input  ram_pkg::bank_addr_t  raddr,
  output ram_pkg::data_t       rdata
);

  import ram_pkg::*;

  // storage array, one entry per word of the bank.
  data_t mem [bank_depth];

  // write port.
  // we doubles as the clock enable, as on the block RAM.
  always_ff @(posedge wclk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read port with a registered output.
  // a same-edge write to the same word is not seen here, the old byte comes out.
  always_ff @(posedge rclk) begin
    if (re) begin
      rdata <= mem[raddr];   // holds between reads.
    end
  end

endmodule

// File: design/ram_pkg.sv
package ram_pkg;

  // one byte per word.
  localparam int data_width = 8;

  // each bank is one 512 x 8 block RAM.
  localparam int bank_depth = 512;
  localparam int num_banks  = 3;

  // 1536 words in all, so the top quarter of the address space is unused.
  localparam int mem_depth = num_banks * bank_depth;

  // byte stored in a bank.
  typedef logic [data_width-1:0] data_t;

  // full address, 11 bits.
  typedef logic [$clog2(mem_depth)-1:0] addr_t;

  // word address inside one bank, 9 bits.
  typedef logic [$clog2(bank_depth)-1:0] bank_addr_t;

  // bank index from the two top address bits.
  // index 3 has no bank behind it and marks an out-of-range access.
  typedef logic [$bits(addr_t)-$bits(bank_addr_t)-1:0] bank_sel_t;

endpackage

// File: design/read_select.sv
`timescale 1ns/1ns

module read_select (
  input  logic                                    rclk,
  input  logic                                    rst_n,
  input  logic                                    re,
  input  ram_pkg::bank_sel_t                      rd_bank,
  input  ram_pkg::data_t [ram_pkg::num_banks-1:0] bank_rdata,
  output ram_pkg::data_t                          rdata,
  output logic                                    rvalid
);

  import ram_pkg::*;

  bank_sel_t rd_bank_q;     // bank of the read now on the bank outputs.

  // rvalid and the bank index move on the same edge as the bank outputs,
  // so the data and its index always belong to the same request.
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid    <= 1'b0;
      rd_bank_q <= '1;       // no bank selected after reset.
    end else begin
      rvalid <= re;          // every read gets one valid cycle.
      if (re) begin
        rd_bank_q <= rd_bank;
      end
    end
  end

  // only a real bank index matches, so index 3 and idle cycles give zero.
  always_comb begin
    rdata = '0;
    if (rvalid) begin
      for (int b = 0; b < num_banks; b++) begin
        if (rd_bank_q == bank_sel_t'(b)) begin
          rdata = bank_rdata[b];
        end
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ram_1536x8 -f vlog.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: test/ram_1536x8_sva.sv
`timescale 1ns/1ns

module ram_1536x8_sva (
  input logic                          rclk,
  input logic                          rst_n,
  input logic                          re,
  input logic                          rvalid,
  input ram_pkg::data_t                rdata,
  input logic [ram_pkg::num_banks-1:0] bank_we,
  input logic [ram_pkg::num_banks-1:0] bank_re
);

  int we_fails    = 0;
  int re_fails    = 0;
  int valid_fails = 0;
  int zero_fails  = 0;
  int fail_count;

  assign fail_count = we_fails + re_fails + valid_fails + zero_fails;

  // sampled mid-cycle, where inputs and registered outputs are both steady.
  a_we_onehot : assert property (@(negedge rclk) $onehot0(bank_we))
    else begin
      $error("ERROR %0t: more than one bank write enable high", $time);
      we_fails++;
    end

  a_re_onehot : assert property (@(negedge rclk) $onehot0(bank_re))
    else begin
      $error("ERROR %0t: more than one bank read enable high", $time);
      re_fails++;
    end

  a_valid_follows : assert property (
    @(negedge rclk) disable iff (!rst_n) rvalid == $past(re))
    else begin
      $error("ERROR %0t: rvalid does not follow re by one cycle", $time);
      valid_fails++;
    end

  a_idle_zero : assert property (@(negedge rclk) !rvalid |-> rdata == '0)
    else begin
      $error("ERROR %0t: rdata not zero while rvalid is low", $time);
      zero_fails++;
    end

endmodule

bind ram_1536x8 ram_1536x8_sva sva0 (
  .rclk    (rclk),
  .rst_n   (rst_n),
  .re      (re),
  .rvalid  (rvalid),
  .rdata   (rdata),
  .bank_we (bank_we),
  .bank_re (bank_re)
);

// File: test/ram_checker.sv
`timescale 1ns/1ns

module ram_checker (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            we,
  input  logic            re,
  input  ram_pkg::addr_t  waddr,
  input  ram_pkg::addr_t  raddr,
  input  ram_pkg::data_t  wdata,
  input  ram_pkg::data_t  rdata,
  input  logic            rvalid,
  output int              err_count,
  output int              check_count
);

  import ram_pkg::*;

  // model covers the whole address space, in range or not.
  data_t model   [2**$bits(addr_t)];
  bit    written [2**$bits(addr_t)];

  logic  exp_pending = 1'b0;  // a read was taken at the last rising edge.
  logic  exp_known   = 1'b0;  // false for a word never written.
  data_t exp_data    = '0;
  addr_t exp_addr    = '0;

  initial begin
    err_count   = 0;
    check_count = 0;
  end

  // inputs are stable at the rising edge, so predict here.
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pending = 1'b0;
    end else begin
      exp_pending = re;
      if (re) begin
        exp_addr = raddr;
        if (raddr >= mem_depth) begin
          exp_known = 1'b1;   // no bank there, zero comes back.
          exp_data  = '0;
        end else begin
          exp_known = written[raddr];
          exp_data  = model[raddr];
        end
      end
      // update after the read so a same-edge read sees the old byte.
      if (we && waddr < mem_depth) begin
        model[waddr]   = wdata;
        written[waddr] = 1'b1;
      end
    end
  end

  // outputs have settled by mid-cycle.
  always @(negedge clk) begin
    check_count++;
    if (exp_pending) begin
      if (rvalid !== 1'b1) begin
        err_count++;
        $display("ERROR %0t: rvalid low for read of %h", $time, exp_addr);
      end else if (exp_known && rdata !== exp_data) begin
        err_count++;
        $display("ERROR %0t: read of %h gave %h, expected %h",
                 $time, exp_addr, rdata, exp_data);
      end
    end else if (rvalid !== 1'b0 || rdata !== '0) begin
      err_count++;
      $display("ERROR %0t: rvalid %b rdata %h with no read pending",
               $time, rvalid, rdata);
    end
  end

endmodule

// File: test/ram_stim.txt
// columns: op (1 digit), write address (3), read address (3), data (2), no spaces
// op 0 idle, 1 write, 2 read, 3 write and read, f ends the list
100000011
11FF00022
120000033
13FF00044
140000055
15FF00066
// out of range writes, must be dropped
1600000EE
17FF000DD
100100077
120100088
140100099
000000000
// read back the bank edges
200000000
20001FF00
200020000
20003FF00
200040000
20005FF00
000000000
// out of range reads return zero
200060000
20007FF00
// back to back reads across banks
200000100
200020100
200040100
200000000
200040000
200020100
000000000
// same address read and write, then read again
32012015A
200020100
34021FFC3
200040200
3600600BB
200000000
000000000
000000000
f00000000

// File: test/tb_ram_1536x8.sv
`timescale 1ns/1ns

module tb_ram_1536x8;

  import ram_pkg::*;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  we;
  logic  re;
  addr_t waddr;
  addr_t raddr;
  data_t wdata;
  data_t rdata;
  logic  rvalid;
  int    err_count;
  int    check_count;

  // one stimulus word per line: op, write address, read address, data.
  logic [35:0] stim [64];
  int          n_lines;
  int          cycle_count = 0;
  int          cycle_limit = 1000;

  ram_1536x8 dut0 (
    .wclk   (clk),
    .rclk   (clk),          // both ports run from the same clock here.
    .rst_n  (rst_n),
    .we     (we),
    .re     (re),
    .waddr  (waddr),
    .raddr  (raddr),
    .wdata  (wdata),
    .rdata  (rdata),
    .rvalid (rvalid)
  );

  ram_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .we          (we),
    .re          (re),
    .waddr       (waddr),
    .raddr       (raddr),
    .wdata       (wdata),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .err_count   (err_count),
    .check_count (check_count)
  );

  always #50 clk = ~clk;    // 100 ns period.

  // op bit 0 is the write strobe, op bit 1 the read strobe.
  task automatic apply_line(input logic [35:0] w);
    logic [3:0] op;
    op    = w[35:32];
    we    = op[0];
    re    = op[1];
    waddr = w[30:20];
    raddr = w[18:8];
    wdata = w[7:0];
  endtask

  initial begin
    rst_n = 1'b0;
    we    = 1'b0;
    re    = 1'b0;
    waddr = '0;
    raddr = '0;
    wdata = '0;
    $readmemh("test/ram_stim.txt", stim);
    n_lines = 0;
    while (n_lines < 64 && stim[n_lines][35:32] != 4'hf) begin
      n_lines++;
    end
    cycle_limit = 2 * n_lines + 20;

    repeat (8) @(posedge clk);
    #5 rst_n = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      apply_line(stim[i]);
      @(posedge clk);
      #5;
    end
    we = 1'b0;
    re = 1'b0;
    repeat (2) begin        // let the last read come back and be checked.
      @(posedge clk);
      #5;
    end

    $display("checks %0d, checker errors %0d, assertion errors %0d",
             check_count, err_count, dut0.sva0.fail_count);
    if (err_count == 0 && dut0.sva0.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // guard against a stimulus loop that never ends.
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout, the run did not end within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

// File: vlog.f
design/ram_pkg.sv
design/bank_decode.sv
design/ram_bank_512x8.sv
design/read_select.sv
design/ram_1536x8.sv
test/ram_1536x8_sva.sv
test/ram_checker.sv
test/tb_ram_1536x8.sv
